/* include/mem_subsys_defs.svh */
`ifndef MEM_SUBSYS_DEFS_SVH
`define MEM_SUBSYS_DEFS_SVH

`define MEM_ADDR_W        32              // bus address width

// sram region of SRAM_WORDS * 4 bytes
`define SRAM_WORDS        1024
`define SRAM_BASE         32'h8000_0000

// 16-byte timer region with mtime at +0 and mtimecmp at +4
`define MTIMER_BASE       32'h0200_0000

`define AXIL_RESP_OKAY    2'b00
`define AXIL_RESP_DECERR  2'b11           // no slave at this address

`endif

/* mem_subsys.f */
+incdir+include
verilog/mem_subsys_pkg.sv
verilog/lsu_axil_master.sv
verilog/axil_addr_decoder.sv
verilog/axil_sram.sv
verilog/axil_mtimer.sv
verilog/mem_subsys_top.sv
tb/tb_mem_subsys.sv

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f mem_subsys.f \
    --top-module tb_mem_subsys -Mdir obj_dir -o sim_mem_subsys

sim_status=0
./obj_dir/sim_mem_subsys > sim.log 2>&1 || sim_status=$?
cat sim.log

if grep -q "TESTBENCH PASSED" sim.log && [ "$sim_status" -eq 0 ]; then
    echo "simulation ok"
else
    echo "simulation reported failure"
    exit 1
fi

/* tb/mem_subsys_golden.txt */
# name store size(0=byte,1=half,2=word) unsigned addr wdata exp_rdata exp_err
# addr, wdata and exp_rdata are hex; exp_rdata "-" means the value is checked by the testbench
sw_base          1 2 0 80000000 11223344 00000000 0
sb_lane1         1 0 0 80000001 000000aa 00000000 0
sh_upper         1 1 0 80000002 0000beef 00000000 0
lw_merged        0 2 0 80000000 00000000 beefaa44 0
sw_pattern       1 2 0 80000010 80ff7f01 00000000 0
lb_lane0         0 0 0 80000010 00000000 00000001 0
lb_lane1         0 0 0 80000011 00000000 0000007f 0
lb_lane2         0 0 0 80000012 00000000 ffffffff 0
lbu_lane2        0 0 1 80000012 00000000 000000ff 0
lb_lane3         0 0 0 80000013 00000000 ffffff80 0
lbu_lane3        0 0 1 80000013 00000000 00000080 0
lh_low           0 1 0 80000010 00000000 00007f01 0
lh_high          0 1 0 80000012 00000000 ffff80ff 0
lhu_high         0 1 1 80000012 00000000 000080ff 0
sh_misaligned    1 1 0 80000011 00001234 00000000 1
sw_misaligned    1 2 0 80000012 deadbeef 00000000 1
lw_misaligned    0 2 0 80000002 00000000 00000000 1
lh_misaligned    0 1 0 80000003 00000000 00000000 1
lw_unchanged     0 2 0 80000010 00000000 80ff7f01 0
sw_unmapped      1 2 0 40000000 12345678 00000000 1
lw_unmapped      0 2 0 40000000 00000000 00000000 1
lb_past_sram     0 0 0 80001000 00000000 00000000 1
mtime_first      0 2 0 02000000 00000000 - 0
mtime_second     0 2 0 02000000 00000000 - 0
sw_mtimecmp      1 2 0 02000004 12345678 00000000 0
lw_mtimecmp      0 2 0 02000004 00000000 12345678 0
sw_mtimecmp_zero 1 2 0 02000004 00000000 00000000 0
lw_mtimecmp_zero 0 2 0 02000004 00000000 00000000 0

/* tb/tb_mem_subsys.sv */
`timescale 1ns/10ps
`include "mem_subsys_defs.svh"

module tb_mem_subsys;

    localparam int DONE_TIMEOUT = 100;  // cycles per request

    logic                     clk;
    logic                     rst_n;
    logic                     req_valid;
    mem_subsys_pkg::lsu_req_t req;
    logic                     done;
    mem_subsys_pkg::lsu_rsp_t rsp;
    logic                     timer_irq;

    int          errors;
    int          checks;
    int          tests;
    logic [31:0] cmp_model;       // expected mtimecmp contents
    logic [31:0] prev_time;
    logic        have_prev_time;

    mem_subsys_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .done      (done),
        .rsp       (rsp),
        .timer_irq (timer_irq)
    );

    always #10 clk = ~clk;

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("Mismatch %s %s: expected %08h, actual %08h", test, what, expected, actual);
            errors++;
        end
    endtask

    // one-cycle req strobe, then poll done at each falling edge
    task automatic issue_request(input mem_subsys_pkg::lsu_req_t next_req,
                                 output logic got_done);
        int cycles;
        cycles   = 0;
        got_done = 1'b0;
        @(negedge clk);
        req_valid = 1'b1;
        req       = next_req;
        while (!got_done && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            req_valid = 1'b0;
            cycles++;
            if (done)
                got_done = 1'b1;
        end
    endtask

    initial begin
        int                       fd;
        int                       code;
        int                       st;
        int                       sz;
        int                       uns;
        int                       exp_err;
        string                    name;
        string                    exp_str;
        string                    rest;
        logic [31:0]              addr;
        logic [31:0]              wdata;
        logic [31:0]              exp_rdata;
        logic                     ignore_data;
        logic                     got_done;
        logic                     aborted;
        mem_subsys_pkg::lsu_req_t next_req;

        clk            = 1'b0;
        rst_n          = 1'b0;
        req_valid      = 1'b0;
        req            = '0;
        errors         = 0;
        checks         = 0;
        tests          = 0;
        cmp_model      = '1;  // mtimecmp reset value
        prev_time      = '0;
        have_prev_time = 1'b0;
        aborted        = 1'b0;
        exp_rdata      = '0;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        check_value("after_reset", "timer_irq", 32'd0, {31'd0, timer_irq});

        fd = $fopen("tb/mem_subsys_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open the golden file tb/mem_subsys_golden.txt");
            errors++;
            aborted = 1'b1;
        end

        while (!aborted && !$feof(fd)) begin
            code = $fscanf(fd, "%s", name);
            if (code != 1)
                break;
            if (name.substr(0, 0) == "#") begin  // column description
                code = $fgets(rest, fd);
                continue;
            end
            code = $fscanf(fd, "%d %d %d %h %h %s %d",
                           st, sz, uns, addr, wdata, exp_str, exp_err);
            if (code != 7) begin
                $display("golden line for %s could not be parsed", name);
                errors++;
                aborted = 1'b1;
            end else begin
                ignore_data = (exp_str == "-");
                if (!ignore_data)
                    code = $sscanf(exp_str, "%h", exp_rdata);

                next_req.is_store    = st[0];
                next_req.size        = mem_subsys_pkg::lsu_size_e'(sz[1:0]);
                next_req.is_unsigned = uns[0];
                next_req.addr        = addr;
                next_req.wdata       = wdata;

                issue_request(next_req, got_done);
                tests++;

                if (!got_done) begin
                    $display("done never arrived for test %s within %0d cycles",
                             name, DONE_TIMEOUT);
                    errors++;
                    aborted = 1'b1;
                end else begin
                    check_value(name, "err", exp_err, {31'd0, rsp.err});
                    if (ignore_data) begin  // mtime must keep counting up
                        if (have_prev_time) begin
                            checks++;
                            assert (rsp.rdata > prev_time) else begin
                                $display("Mismatch %s rdata: expected above %08h, actual %08h",
                                         name, prev_time, rsp.rdata);
                                errors++;
                            end
                        end
                        prev_time      = rsp.rdata;
                        have_prev_time = 1'b1;
                    end else begin
                        check_value(name, "rdata", exp_rdata, rsp.rdata);
                    end

                    if (st != 0 && sz == 2 && addr == `MTIMER_BASE + 4 && exp_err == 0)
                        cmp_model = wdata;
                    // irq follows mtime >= mtimecmp
                    if (cmp_model == 32'd0)
                        check_value(name, "timer_irq", 32'd1, {31'd0, timer_irq});
                    else if (cmp_model == '1)
                        check_value(name, "timer_irq", 32'd0, {31'd0, timer_irq});
                end
            end
        end

        if (fd != 0)
            $fclose(fd);
        if (tests == 0 && !aborted) begin
            $display("no requests were read from the golden file");
            errors++;
        end

        $display("tests run: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* verilog/axil_addr_decoder.sv */
`timescale 1ns/10ps
`include "mem_subsys_defs.svh"

module axil_addr_decoder (
    input  logic                     clk,
    input  logic                     rst_n,
    input  mem_subsys_pkg::axil_aw_t aw,
    input  mem_subsys_pkg::axil_w_t  w,
    input  mem_subsys_pkg::axil_ar_t ar,
    input  logic                     aw_valid, w_valid, ar_valid, b_ready, r_ready,
    output logic                     aw_ready, w_ready, ar_ready, b_valid, r_valid,
    output mem_subsys_pkg::axil_b_t  b,
    output mem_subsys_pkg::axil_r_t  r,
    output mem_subsys_pkg::axil_aw_t sram_aw,
    output mem_subsys_pkg::axil_w_t  sram_w,
    output mem_subsys_pkg::axil_ar_t sram_ar,
    output logic                     sram_aw_valid, sram_w_valid, sram_ar_valid,
    output logic                     sram_b_ready, sram_r_ready,
    input  logic                     sram_aw_ready, sram_w_ready, sram_ar_ready,
    input  logic                     sram_b_valid, sram_r_valid,
    input  mem_subsys_pkg::axil_b_t  sram_b,
    input  mem_subsys_pkg::axil_r_t  sram_r,
    output mem_subsys_pkg::axil_aw_t tmr_aw,
    output mem_subsys_pkg::axil_w_t  tmr_w,
    output mem_subsys_pkg::axil_ar_t tmr_ar,
    output logic                     tmr_aw_valid, tmr_w_valid, tmr_ar_valid,
    output logic                     tmr_b_ready, tmr_r_ready,
    input  logic                     tmr_aw_ready, tmr_w_ready, tmr_ar_ready,
    input  logic                     tmr_b_valid, tmr_r_valid,
    input  mem_subsys_pkg::axil_b_t  tmr_b,
    input  mem_subsys_pkg::axil_r_t  tmr_r
);

    localparam logic [1:0] TGT_SRAM = 2'd0;
    localparam logic [1:0] TGT_TMR  = 2'd1;
    localparam logic [1:0] TGT_ERR  = 2'd2;

    logic [1:0] aw_tgt, ar_tgt;
    logic [1:0] wr_own, rd_own;      // owner of the outstanding transfer
    logic       wr_pend, rd_pend;
    logic       err_b_valid, err_r_valid;
    logic       err_wr_acc, err_rd_acc;

    function automatic logic [1:0] decode(input logic [`MEM_ADDR_W-1:0] a);
        if (a >= `SRAM_BASE && a < `SRAM_BASE + `SRAM_WORDS * 4)
            return TGT_SRAM;
        if (a >= `MTIMER_BASE && a < `MTIMER_BASE + 16)
            return TGT_TMR;
        return TGT_ERR;
    endfunction

    assign aw_tgt = decode(aw.addr);
    assign ar_tgt = decode(ar.addr);

    assign sram_aw = aw;
    assign sram_w  = w;
    assign sram_ar = ar;
    assign tmr_aw  = aw;
    assign tmr_w   = w;
    assign tmr_ar  = ar;

    // w follows the aw address since the master sends both together
    assign sram_aw_valid = aw_valid && aw_tgt == TGT_SRAM;
    assign sram_w_valid  = w_valid && aw_tgt == TGT_SRAM;
    assign sram_ar_valid = ar_valid && ar_tgt == TGT_SRAM;
    assign tmr_aw_valid  = aw_valid && aw_tgt == TGT_TMR;
    assign tmr_w_valid   = w_valid && aw_tgt == TGT_TMR;
    assign tmr_ar_valid  = ar_valid && ar_tgt == TGT_TMR;

    assign err_wr_acc = aw_valid && w_valid && aw_tgt == TGT_ERR && !err_b_valid;
    assign err_rd_acc = ar_valid && ar_tgt == TGT_ERR && !err_r_valid;

    always_comb begin
        case (aw_tgt)
            TGT_SRAM: {aw_ready, w_ready} = {sram_aw_ready, sram_w_ready};
            TGT_TMR:  {aw_ready, w_ready} = {tmr_aw_ready, tmr_w_ready};
            default:  {aw_ready, w_ready} = {2{err_wr_acc}};
        endcase
        case (ar_tgt)
            TGT_SRAM: ar_ready = sram_ar_ready;
            TGT_TMR:  ar_ready = tmr_ar_ready;
            default:  ar_ready = err_rd_acc;
        endcase
    end

    always_comb begin
        case (wr_own)
            TGT_SRAM: {b_valid, b} = {sram_b_valid & wr_pend, sram_b};
            TGT_TMR:  {b_valid, b} = {tmr_b_valid & wr_pend, tmr_b};
            default:  {b_valid, b} = {err_b_valid, `AXIL_RESP_DECERR};
        endcase
        case (rd_own)
            TGT_SRAM: {r_valid, r} = {sram_r_valid & rd_pend, sram_r};
            TGT_TMR:  {r_valid, r} = {tmr_r_valid & rd_pend, tmr_r};
            default:  {r_valid, r} = {err_r_valid, 32'd0, `AXIL_RESP_DECERR};
        endcase
    end

    assign sram_b_ready = b_ready && wr_own == TGT_SRAM;
    assign tmr_b_ready  = b_ready && wr_own == TGT_TMR;
    assign sram_r_ready = r_ready && rd_own == TGT_SRAM;
    assign tmr_r_ready  = r_ready && rd_own == TGT_TMR;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_pend     <= 1'b0;
            rd_pend     <= 1'b0;
            wr_own      <= TGT_SRAM;
            rd_own      <= TGT_SRAM;
            err_b_valid <= 1'b0;
            err_r_valid <= 1'b0;
        end else begin
            if (aw_valid && aw_ready) begin
                wr_pend <= 1'b1;
                wr_own  <= aw_tgt;
            end else if (b_valid && b_ready) begin
                wr_pend <= 1'b0;
            end
            if (ar_valid && ar_ready) begin
                rd_pend <= 1'b1;
                rd_own  <= ar_tgt;
            end else if (r_valid && r_ready) begin
                rd_pend <= 1'b0;
            end
            if (err_wr_acc)
                err_b_valid <= 1'b1;  // decerr one cycle after the miss
            else if (err_b_valid && b_ready)
                err_b_valid <= 1'b0;
            if (err_rd_acc)
                err_r_valid <= 1'b1;
            else if (err_r_valid && r_ready)
                err_r_valid <= 1'b0;
        end
    end

    // one transfer per direction in flight
    assert property (@(posedge clk) disable iff (!rst_n)
        (aw_valid && aw_ready) |-> !wr_pend);
    assert property (@(posedge clk) disable iff (!rst_n)
        (ar_valid && ar_ready) |-> !rd_pend);

endmodule

/* verilog/axil_mtimer.sv */
`timescale 1ns/10ps
`include "mem_subsys_defs.svh"

module axil_mtimer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  mem_subsys_pkg::axil_aw_t aw,
    input  logic                     aw_valid,
    output logic                     aw_ready,
    input  mem_subsys_pkg::axil_w_t  w,
    input  logic                     w_valid,
    output logic                     w_ready,
    output mem_subsys_pkg::axil_b_t  b,
    output logic                     b_valid,
    input  logic                     b_ready,
    input  mem_subsys_pkg::axil_ar_t ar,
    input  logic                     ar_valid,
    output logic                     ar_ready,
    output mem_subsys_pkg::axil_r_t  r,
    output logic                     r_valid,
    input  logic                     r_ready,
    output logic                     irq
);

    localparam logic [1:0] REG_TIME = 2'd0;  // offset 0
    localparam logic [1:0] REG_CMP  = 2'd1;  // offset 4

    logic [31:0] mtime;
    logic [31:0] mtimecmp;
    logic [31:0] rdata_q;
    logic        wr_acc;
    logic        rd_acc;

    assign wr_acc   = aw_valid && w_valid && !b_valid;
    assign rd_acc   = ar_valid && !r_valid && !wr_acc;
    assign aw_ready = wr_acc;
    assign w_ready  = wr_acc;
    assign ar_ready = rd_acc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime    <= '0;
            mtimecmp <= '1;  // irq stays off until software arms it
            b_valid  <= 1'b0;
            r_valid  <= 1'b0;
        end else begin
            mtime <= mtime + 32'd1;
            if (wr_acc && aw.addr[3:2] == REG_CMP) begin
                for (int i = 0; i < 4; i++) begin
                    if (w.strb[i])
                        mtimecmp[8*i +: 8] <= w.data[8*i +: 8];
                end
            end
            if (wr_acc)
                b_valid <= 1'b1;
            else if (b_ready)
                b_valid <= 1'b0;
            if (rd_acc)
                r_valid <= 1'b1;
            else if (r_ready)
                r_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_acc) begin
            case (ar.addr[3:2])
                REG_TIME: rdata_q <= mtime;
                REG_CMP:  rdata_q <= mtimecmp;
                default:  rdata_q <= 32'd0;  // upper words unused
            endcase
        end
    end

    assign b   = '{resp: `AXIL_RESP_OKAY};
    assign r   = '{data: rdata_q, resp: `AXIL_RESP_OKAY};
    assign irq = mtime >= mtimecmp;

endmodule

/* verilog/axil_sram.sv */
`timescale 1ns/10ps
`include "mem_subsys_defs.svh"

module axil_sram (
    input  logic                     clk,
    input  logic                     rst_n,
    input  mem_subsys_pkg::axil_aw_t aw,
    input  logic                     aw_valid,
    output logic                     aw_ready,
    input  mem_subsys_pkg::axil_w_t  w,
    input  logic                     w_valid,
    output logic                     w_ready,
    output mem_subsys_pkg::axil_b_t  b,
    output logic                     b_valid,
    input  logic                     b_ready,
    input  mem_subsys_pkg::axil_ar_t ar,
    input  logic                     ar_valid,
    output logic                     ar_ready,
    output mem_subsys_pkg::axil_r_t  r,
    output logic                     r_valid,
    input  logic                     r_ready
);

    localparam int IDX_W = $clog2(`SRAM_WORDS);

    logic [31:0]      mem [0:`SRAM_WORDS-1];
    logic [31:0]      dout;
    logic [IDX_W-1:0] idx;
    logic             wr_acc;
    logic             rd_acc;

    assign wr_acc = aw_valid && w_valid && !b_valid;
    assign rd_acc = ar_valid && !r_valid && !wr_acc;  // writes win the port

    assign aw_ready = wr_acc;
    assign w_ready  = wr_acc;
    assign ar_ready = rd_acc;

    assign idx = wr_acc ? aw.addr[IDX_W+1:2] : ar.addr[IDX_W+1:2];  // word index

    always_ff @(posedge clk) begin
        if (wr_acc) begin
            for (int i = 0; i < 4; i++) begin
                if (w.strb[i])
                    mem[idx][8*i +: 8] <= w.data[8*i +: 8];
            end
        end else if (rd_acc) begin
            dout <= mem[idx];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            b_valid <= 1'b0;
            r_valid <= 1'b0;
        end else begin
            if (wr_acc)
                b_valid <= 1'b1;
            else if (b_ready)
                b_valid <= 1'b0;
            if (rd_acc)
                r_valid <= 1'b1;
            else if (r_ready)
                r_valid <= 1'b0;
        end
    end

    assign b = '{resp: `AXIL_RESP_OKAY};
    assign r = '{data: dout, resp: `AXIL_RESP_OKAY};

    // an address held off by the port stays valid and unchanged
    assert property (@(posedge clk) disable iff (!rst_n)
        (aw_valid && !aw_ready) |=> (aw_valid && $stable(aw.addr)));
    assert property (@(posedge clk) disable iff (!rst_n)
        (ar_valid && !ar_ready) |=> (ar_valid && $stable(ar.addr)));

endmodule

/* verilog/lsu_axil_master.sv */
`timescale 1ns/10ps
`include "mem_subsys_defs.svh"

module lsu_axil_master (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req_valid,
    input  mem_subsys_pkg::lsu_req_t req,
    output logic                     done,
    output mem_subsys_pkg::lsu_rsp_t rsp,
    output logic                     aw_valid,
    output logic                     w_valid,
    output logic                     ar_valid,
    output mem_subsys_pkg::axil_aw_t aw,
    output mem_subsys_pkg::axil_w_t  w,
    output mem_subsys_pkg::axil_ar_t ar,
    input  logic                     aw_ready,
    input  logic                     w_ready,
    input  logic                     ar_ready,
    input  mem_subsys_pkg::axil_b_t  b,
    input  logic                     b_valid,
    output logic                     b_ready,
    input  mem_subsys_pkg::axil_r_t  r,
    input  logic                     r_valid,
    output logic                     r_ready
);

    mem_subsys_pkg::lsu_req_t req_q;
    logic        wr_busy;
    logic        rd_busy;
    logic        misaligned;
    logic [4:0]  lane_shift;  // byte offset in bits
    logic [31:0] lane_data;
    logic [31:0] load_data;

    always_comb begin
        case (req.size)
            mem_subsys_pkg::LSU_BYTE: misaligned = 1'b0;
            mem_subsys_pkg::LSU_HALF: misaligned = req.addr[0];
            default:                  misaligned = |req.addr[1:0];
        endcase
    end

    always_ff @(posedge clk) begin
        if (req_valid)
            req_q <= req;
    end

    assign lane_shift = {req_q.addr[1:0], 3'b000};

    assign aw = '{addr: req_q.addr, prot: 3'b000};
    assign ar = '{addr: req_q.addr, prot: 3'b000};
    assign w.data = req_q.wdata << lane_shift;  // move store data into its lane

    always_comb begin
        case (req_q.size)
            mem_subsys_pkg::LSU_BYTE: w.strb = 4'b0001 << req_q.addr[1:0];
            mem_subsys_pkg::LSU_HALF: w.strb = 4'b0011 << req_q.addr[1:0];
            default:                  w.strb = 4'b1111;
        endcase
    end

    assign lane_data = r.data >> lane_shift;

    always_comb begin
        case (req_q.size)
            mem_subsys_pkg::LSU_BYTE:
                load_data = {{24{lane_data[7] & ~req_q.is_unsigned}}, lane_data[7:0]};
            mem_subsys_pkg::LSU_HALF:
                load_data = {{16{lane_data[15] & ~req_q.is_unsigned}}, lane_data[15:0]};
            default:
                load_data = lane_data;
        endcase
    end

    assign b_ready = wr_busy;  // ready through the whole wait
    assign r_ready = rd_busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_valid <= 1'b0;
            w_valid  <= 1'b0;
            ar_valid <= 1'b0;
            wr_busy  <= 1'b0;
            rd_busy  <= 1'b0;
            done     <= 1'b0;
            rsp      <= '0;
        end else begin
            done <= 1'b0;
            if (aw_valid && aw_ready)
                aw_valid <= 1'b0;
            if (w_valid && w_ready)
                w_valid <= 1'b0;
            if (ar_valid && ar_ready)
                ar_valid <= 1'b0;
            if (req_valid) begin
                if (misaligned) begin  // rejected without bus traffic
                    done <= 1'b1;
                    rsp  <= '{rdata: 32'd0, err: 1'b1};
                end else if (req.is_store) begin
                    aw_valid <= 1'b1;
                    w_valid  <= 1'b1;
                    wr_busy  <= 1'b1;
                end else begin
                    ar_valid <= 1'b1;
                    rd_busy  <= 1'b1;
                end
            end
            if (b_valid && b_ready) begin
                wr_busy <= 1'b0;
                done    <= 1'b1;
                rsp     <= '{rdata: 32'd0, err: b.resp != `AXIL_RESP_OKAY};
            end
            if (r_valid && r_ready) begin
                rd_busy <= 1'b0;
                done    <= 1'b1;
                rsp     <= '{rdata: load_data, err: r.resp != `AXIL_RESP_OKAY};
            end
        end
    end

    // the request port has no back-pressure
    assert property (@(posedge clk) disable iff (!rst_n)
        req_valid |-> !(wr_busy || rd_busy));

endmodule

/* verilog/mem_subsys_pkg.sv */
`include "mem_subsys_defs.svh"

package mem_subsys_pkg;

    typedef enum logic [1:0] {
        LSU_BYTE = 2'd0,
        LSU_HALF = 2'd1,
        LSU_WORD = 2'd2
    } lsu_size_e;

    typedef struct packed {
        logic                    is_store;
        lsu_size_e               size;
        logic                    is_unsigned;  // zero-extend loads
        logic [`MEM_ADDR_W-1:0]  addr;
        logic [31:0]             wdata;        // store data in the low bits
    } lsu_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        err;
    } lsu_rsp_t;

    typedef struct packed {
        logic [`MEM_ADDR_W-1:0] addr;
        logic [2:0]             prot;
    } axil_aw_t;

    typedef struct packed {
        logic [`MEM_ADDR_W-1:0] addr;
        logic [2:0]             prot;
    } axil_ar_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
    } axil_w_t;

    typedef struct packed {
        logic [1:0] resp;
    } axil_b_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
    } axil_r_t;

endpackage

/* verilog/mem_subsys_top.sv */
`timescale 1ns/10ps

module mem_subsys_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req_valid,
    input  mem_subsys_pkg::lsu_req_t req,
    output logic                     done,
    output mem_subsys_pkg::lsu_rsp_t rsp,
    output logic                     timer_irq
);

    // master to decoder
    mem_subsys_pkg::axil_aw_t m_aw, s_aw, t_aw;
    mem_subsys_pkg::axil_w_t  m_w, s_w, t_w;
    mem_subsys_pkg::axil_ar_t m_ar, s_ar, t_ar;
    mem_subsys_pkg::axil_b_t  m_b, s_b, t_b;
    mem_subsys_pkg::axil_r_t  m_r, s_r, t_r;
    logic m_aw_valid, m_w_valid, m_ar_valid, m_b_valid, m_r_valid;
    logic m_aw_ready, m_w_ready, m_ar_ready, m_b_ready, m_r_ready;
    // decoder to sram
    logic s_aw_valid, s_w_valid, s_ar_valid, s_b_valid, s_r_valid;
    logic s_aw_ready, s_w_ready, s_ar_ready, s_b_ready, s_r_ready;
    // decoder to timer
    logic t_aw_valid, t_w_valid, t_ar_valid, t_b_valid, t_r_valid;
    logic t_aw_ready, t_w_ready, t_ar_ready, t_b_ready, t_r_ready;

    lsu_axil_master i_master (
        .clk(clk), .rst_n(rst_n),
        .req_valid(req_valid), .req(req), .done(done), .rsp(rsp),
        .aw_valid(m_aw_valid), .w_valid(m_w_valid), .ar_valid(m_ar_valid),
        .aw(m_aw), .w(m_w), .ar(m_ar),
        .aw_ready(m_aw_ready), .w_ready(m_w_ready), .ar_ready(m_ar_ready),
        .b(m_b), .b_valid(m_b_valid), .b_ready(m_b_ready),
        .r(m_r), .r_valid(m_r_valid), .r_ready(m_r_ready)
    );

    axil_addr_decoder i_decoder (
        .clk(clk), .rst_n(rst_n),
        .aw(m_aw), .w(m_w), .ar(m_ar),
        .aw_valid(m_aw_valid), .w_valid(m_w_valid), .ar_valid(m_ar_valid),
        .b_ready(m_b_ready), .r_ready(m_r_ready),
        .aw_ready(m_aw_ready), .w_ready(m_w_ready), .ar_ready(m_ar_ready),
        .b_valid(m_b_valid), .r_valid(m_r_valid), .b(m_b), .r(m_r),
        .sram_aw(s_aw), .sram_w(s_w), .sram_ar(s_ar),
        .sram_aw_valid(s_aw_valid), .sram_w_valid(s_w_valid), .sram_ar_valid(s_ar_valid),
        .sram_b_ready(s_b_ready), .sram_r_ready(s_r_ready),
        .sram_aw_ready(s_aw_ready), .sram_w_ready(s_w_ready), .sram_ar_ready(s_ar_ready),
        .sram_b_valid(s_b_valid), .sram_r_valid(s_r_valid), .sram_b(s_b), .sram_r(s_r),
        .tmr_aw(t_aw), .tmr_w(t_w), .tmr_ar(t_ar),
        .tmr_aw_valid(t_aw_valid), .tmr_w_valid(t_w_valid), .tmr_ar_valid(t_ar_valid),
        .tmr_b_ready(t_b_ready), .tmr_r_ready(t_r_ready),
        .tmr_aw_ready(t_aw_ready), .tmr_w_ready(t_w_ready), .tmr_ar_ready(t_ar_ready),
        .tmr_b_valid(t_b_valid), .tmr_r_valid(t_r_valid), .tmr_b(t_b), .tmr_r(t_r)
    );

    axil_sram i_sram (
        .clk(clk), .rst_n(rst_n),
        .aw(s_aw), .aw_valid(s_aw_valid), .aw_ready(s_aw_ready),
        .w(s_w), .w_valid(s_w_valid), .w_ready(s_w_ready),
        .b(s_b), .b_valid(s_b_valid), .b_ready(s_b_ready),
        .ar(s_ar), .ar_valid(s_ar_valid), .ar_ready(s_ar_ready),
        .r(s_r), .r_valid(s_r_valid), .r_ready(s_r_ready)
    );

    axil_mtimer i_mtimer (
        .clk(clk), .rst_n(rst_n),
        .aw(t_aw), .aw_valid(t_aw_valid), .aw_ready(t_aw_ready),
        .w(t_w), .w_valid(t_w_valid), .w_ready(t_w_ready),
        .b(t_b), .b_valid(t_b_valid), .b_ready(t_b_ready),
        .ar(t_ar), .ar_valid(t_ar_valid), .ar_ready(t_ar_ready),
        .r(t_r), .r_valid(t_r_valid), .r_ready(t_r_ready),
        .irq(timer_irq)
    );

endmodule
